// ==== rtl/csr_params.svh ====
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

`define XLEN        64
`define VADDR_SIZE  39
`define ROB_WIDTH   5   // index bits, wrap bit not counted
`define EXC_WIDTH   5

`define EXC_II      5'd2
`define EXC_BP      5'd3
`define EXC_EC      5'd8    // mode is added on top
`define EXC_MRET    5'd27   // low bits give the return level
`define EXC_NONE    5'd31

// extension bits and MXL
`define ISA_MASK    64'hc000_0000_03ff_ffff
`define TVEC_MASK   64'hffff_ffff_ffff_fffc   // direct mode only
`define IP_MASK     64'h0000_0000_0000_0aaa
`define CAUSE_MASK  64'h8000_0000_0000_001f
// sie mie spie mpie spp mpp
`define STATUS_MASK 64'h0000_0000_0000_19aa

// rv64 with I, M, A, S and U
`define MISA_INIT   64'h8000_0000_0014_1101

`endif

// ==== rtl/backend_pkg.sv ====
`default_nettype none

`include "csr_params.svh"

package backend_pkg;

    typedef logic [`XLEN-1:0]       xlen_t;
    typedef logic [`VADDR_SIZE-1:0] vaddr_t;
    typedef logic [`ROB_WIDTH:0]    rob_idx_t;   // wrap bit on top
    typedef logic [`EXC_WIDTH-1:0]  exc_code_t;
    typedef logic [4:0]             arch_reg_t;

    // bit 2 picks the immediate, bits 1:0 the function
    typedef logic [2:0]             csr_op_t;

    localparam logic [1:0] CSR_FN_RW = 2'b01;
    localparam logic [1:0] CSR_FN_RS = 2'b10;
    localparam logic [1:0] CSR_FN_RC = 2'b11;   // 00 is ebreak or ecall

endpackage

`default_nettype wire

// ==== rtl/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    typedef logic [11:0] csr_addr_t;
    typedef logic [1:0]  priv_mode_t;

    localparam priv_mode_t PRIV_U = 2'd0;
    localparam priv_mode_t PRIV_S = 2'd1;
    localparam priv_mode_t PRIV_M = 2'd3;

    localparam int CSR_NUM = 23;

    localparam int SLOT_MISA      = 0;
    localparam int SLOT_MVENDORID = 1;
    localparam int SLOT_MARCHID   = 2;
    localparam int SLOT_MIMPID    = 3;
    localparam int SLOT_MHARTID   = 4;
    localparam int SLOT_MSTATUS   = 5;
    localparam int SLOT_MTVEC     = 6;
    localparam int SLOT_MEDELEG   = 7;
    localparam int SLOT_MIDELEG   = 8;
    localparam int SLOT_MIP       = 9;
    localparam int SLOT_MIE       = 10;
    localparam int SLOT_MSCRATCH  = 11;
    localparam int SLOT_MEPC      = 12;
    localparam int SLOT_MCAUSE    = 13;
    localparam int SLOT_MTVAL     = 14;
    localparam int SLOT_SSTATUS   = 15;
    localparam int SLOT_STVEC     = 16;
    localparam int SLOT_SIP       = 17;
    localparam int SLOT_SIE       = 18;
    localparam int SLOT_SEPC      = 19;
    localparam int SLOT_SCAUSE    = 20;
    localparam int SLOT_STVAL     = 21;
    localparam int SLOT_SATP      = 22;

    // in slot order
    localparam csr_addr_t CSR_ADDR_TABLE [CSR_NUM] = '{
        12'h301, 12'hf11, 12'hf12, 12'hf13, 12'hf14,
        12'h300, 12'h305, 12'h302, 12'h303, 12'h344,
        12'h304, 12'h340, 12'h341, 12'h342, 12'h343,
        12'h100, 12'h105, 12'h144, 12'h104, 12'h141,
        12'h142, 12'h143, 12'h180
    };

endpackage

`default_nettype wire

// ==== rtl/rob_age_compare.sv ====
`default_nettype none

`include "csr_params.svh"

module rob_age_compare #(
    parameter int IDX_W = `ROB_WIDTH
) (
    input  backend_pkg::rob_idx_t idx_a,
    input  backend_pkg::rob_idx_t idx_b,
    output logic                  a_older
);

    logic same_lap;
    logic a_below;
    logic a_above;

    assign same_lap = idx_a[IDX_W] == idx_b[IDX_W];
    assign a_below  = idx_a[IDX_W-1:0] < idx_b[IDX_W-1:0];
    assign a_above  = idx_a[IDX_W-1:0] > idx_b[IDX_W-1:0];

    // across a wrap the larger index was allocated first
    assign a_older = same_lap ? a_below : a_above;

endmodule

`default_nettype wire

// ==== rtl/csr_read_select.sv ====
`default_nettype none

module csr_read_select (
    input  csr_pkg::csr_addr_t                  csrid,
    input  backend_pkg::xlen_t                  csr_values [csr_pkg::CSR_NUM],
    output logic [csr_pkg::CSR_NUM-1:0]         hit,
    output backend_pkg::xlen_t                  rdata
);

    import csr_pkg::*;

    genvar i;

    generate
        for (i = 0; i < CSR_NUM; i++) begin : g_cmp
            assign hit[i] = csrid == CSR_ADDR_TABLE[i];
        end
    endgenerate

    // at most one hit, so an OR is the mux
    always_comb begin
        rdata = '0;
        for (int s = 0; s < CSR_NUM; s++) begin
            if (hit[s]) begin
                rdata = rdata | csr_values[s];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/csr_trap_ctrl.sv ====
`default_nettype none

`include "csr_params.svh"

module csr_trap_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   redirect_en,
    input  backend_pkg::exc_code_t redirect_exccode,
    input  backend_pkg::vaddr_t    exc_pc,
    input  logic                   wen_mstatus,
    input  logic                   wen_mepc,
    input  logic                   wen_mcause,
    input  backend_pkg::xlen_t     wdata,
    output backend_pkg::xlen_t     mstatus,
    output backend_pkg::xlen_t     mepc,
    output backend_pkg::xlen_t     mcause,
    output backend_pkg::vaddr_t    target_pc,
    input  backend_pkg::xlen_t     mtvec
);

    import backend_pkg::*;
    import csr_pkg::*;

    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_LO   = 11;
    localparam int MPP_HI   = 12;

    priv_mode_t mode;
    exc_code_t  ecall_code;
    exc_code_t  trap_code;
    logic       is_mret;
    logic       mret_priv_err;
    logic       mret_valid;
    logic       take_trap;
    logic       do_mret;

    assign ecall_code    = `EXC_EC + exc_code_t'(mode);
    assign is_mret       = redirect_exccode == `EXC_MRET;
    assign mret_priv_err = mode < redirect_exccode[1:0];   // return level sits in low bits
    assign mret_valid    = is_mret & ~mret_priv_err;

    // a failed return is reported as an illegal instruction
    always_comb begin
        if (redirect_exccode == `EXC_EC) begin
            trap_code = ecall_code;
        end else if (is_mret) begin
            trap_code = `EXC_II;
        end else begin
            trap_code = redirect_exccode;
        end
    end

    assign take_trap = redirect_en & ~mret_valid;
    assign do_mret   = redirect_en & mret_valid;

    assign target_pc = mret_valid ? mepc[`VADDR_SIZE-1:0]
                                  : {mtvec[`VADDR_SIZE-1:2], 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            mode <= PRIV_M;
        end else if (take_trap) begin
            mode <= PRIV_M;
        end else if (do_mret) begin
            mode <= mstatus[MPP_HI:MPP_LO];
        end
    end

    // trap updates come last so they override a csr write
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= '0;
        end else begin
            if (wen_mstatus) begin
                mstatus <= wdata & `STATUS_MASK;
            end
            if (take_trap) begin
                mstatus[MPP_HI:MPP_LO] <= mode;
                mstatus[MPIE_BIT]      <= mstatus[MIE_BIT];
                mstatus[MIE_BIT]       <= 1'b0;
            end
            if (do_mret) begin
                mstatus[MIE_BIT]  <= mstatus[MPIE_BIT];
                mstatus[MPIE_BIT] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc <= '0;
        end else if (take_trap) begin
            mepc <= xlen_t'(exc_pc);
        end else if (wen_mepc) begin
            mepc <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcause <= '0;
        end else if (take_trap) begin
            mcause <= xlen_t'(trap_code);   // no interrupts, top bit stays clear
        end else if (wen_mcause) begin
            mcause <= wdata & `CAUSE_MASK;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/csr_unit.sv ====
`default_nettype none

`include "csr_params.svh"

module csr_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_en,
    input  backend_pkg::csr_op_t   issue_csrop,
    input  csr_pkg::csr_addr_t     issue_csrid,
    input  backend_pkg::arch_reg_t issue_imm,
    input  backend_pkg::xlen_t     issue_rs1_data,
    input  backend_pkg::rob_idx_t  issue_rob_idx,
    input  backend_pkg::arch_reg_t issue_rd,
    input  logic                   issue_exc_valid,
    input  backend_pkg::exc_code_t issue_exccode,
    output logic                   wb_en,
    output backend_pkg::rob_idx_t  wb_rob_idx,
    output backend_pkg::arch_reg_t wb_rd,
    output backend_pkg::xlen_t     wb_res,
    output backend_pkg::exc_code_t wb_exccode,
    input  logic                   backend_redirect,
    input  backend_pkg::rob_idx_t  backend_redirect_idx,
    input  logic                   redirect_en,
    input  backend_pkg::exc_code_t redirect_exccode,
    input  backend_pkg::vaddr_t    exc_pc,
    output backend_pkg::vaddr_t    target_pc
);

    import backend_pkg::*;
    import csr_pkg::*;

    // WARL mask per slot, zero marks a read-only zero register
    localparam xlen_t CSR_MASK [CSR_NUM] = '{
        `ISA_MASK,                 // misa
        '0,                        // mvendorid
        '0,                        // marchid
        '0,                        // mimpid
        '0,                        // mhartid
        `STATUS_MASK,              // mstatus
        `TVEC_MASK,                // mtvec
        {`XLEN{1'b1}},             // medeleg
        {`XLEN{1'b1}},             // mideleg
        `IP_MASK,                  // mip
        `IP_MASK,                  // mie
        {`XLEN{1'b1}},             // mscratch
        {`XLEN{1'b1}},             // mepc
        `CAUSE_MASK,               // mcause
        {`XLEN{1'b1}},             // mtval
        `STATUS_MASK,              // sstatus
        `TVEC_MASK,                // stvec
        `IP_MASK,                  // sip
        `IP_MASK,                  // sie
        {`XLEN{1'b1}},             // sepc
        `CAUSE_MASK,               // scause
        {`XLEN{1'b1}},             // stval
        {`XLEN{1'b1}}              // satp
    };

    logic               redirect_older;
    logic [CSR_NUM-1:0] csr_hit;
    logic [CSR_NUM-1:0] csr_wen;
    xlen_t              csr_raw [CSR_NUM];
    xlen_t              csr_values [CSR_NUM];
    xlen_t              rdata;
    xlen_t              wdata;
    xlen_t              src;
    xlen_t              mstatus_q;
    xlen_t              mepc_q;
    xlen_t              mcause_q;
    logic [1:0]         csr_fn;
    logic               is_rw;
    logic               is_rs;
    logic               is_rc;
    logic               zero_src;
    logic               wen_ok;

    assign csr_fn   = issue_csrop[1:0];
    assign is_rw    = csr_fn == CSR_FN_RW;
    assign is_rs    = csr_fn == CSR_FN_RS;
    assign is_rc    = csr_fn == CSR_FN_RC;
    assign src      = issue_csrop[2] ? xlen_t'(issue_imm) : issue_rs1_data;
    assign zero_src = (is_rs | is_rc) & (issue_imm == '0);   // csrrs/csrrc with x0 or uimm 0

    always_comb begin
        if (is_rw) begin
            wdata = src;
        end else if (is_rs) begin
            wdata = rdata | src;
        end else begin
            wdata = rdata & ~src;
        end
    end

    rob_age_compare #(
        .IDX_W(`ROB_WIDTH)
    ) u_age (
        .idx_a  (backend_redirect_idx),
        .idx_b  (issue_rob_idx),
        .a_older(redirect_older)
    );

    // ecall and ebreak decode to no function and never write
    assign wen_ok = issue_en & ~issue_exc_valid & (is_rw | is_rs | is_rc) & ~zero_src
                  & ~(backend_redirect & redirect_older);
    assign csr_wen = csr_hit & {CSR_NUM{wen_ok}};

    genvar i;

    generate
        for (i = 0; i < CSR_NUM; i++) begin : g_slot
            if (i == SLOT_MSTATUS) begin : g_mstatus
                assign csr_raw[i] = mstatus_q;
            end else if (i == SLOT_MEPC) begin : g_mepc
                assign csr_raw[i] = mepc_q;
            end else if (i == SLOT_MCAUSE) begin : g_mcause
                assign csr_raw[i] = mcause_q;
            end else if (CSR_MASK[i] == '0) begin : g_zero
                assign csr_raw[i] = '0;   // id registers
            end else begin : g_reg
                xlen_t q;
                always_ff @(posedge clk) begin
                    if (rst) begin
                        q <= (i == SLOT_MISA) ? xlen_t'(`MISA_INIT) : '0;
                    end else if (csr_wen[i]) begin
                        q <= wdata & CSR_MASK[i];
                    end
                end
                assign csr_raw[i] = q;
            end
            assign csr_values[i] = csr_raw[i] & CSR_MASK[i];
        end
    endgenerate

    csr_read_select u_rsel (
        .csrid     (issue_csrid),
        .csr_values(csr_values),
        .hit       (csr_hit),
        .rdata     (rdata)
    );

    csr_trap_ctrl u_trap (
        .clk             (clk),
        .rst             (rst),
        .redirect_en     (redirect_en),
        .redirect_exccode(redirect_exccode),
        .exc_pc          (exc_pc),
        .wen_mstatus     (csr_wen[SLOT_MSTATUS]),
        .wen_mepc        (csr_wen[SLOT_MEPC]),
        .wen_mcause      (csr_wen[SLOT_MCAUSE]),
        .wdata           (wdata),
        .mstatus         (mstatus_q),
        .mepc            (mepc_q),
        .mcause          (mcause_q),
        .target_pc       (target_pc),
        .mtvec           (csr_raw[SLOT_MTVEC])
    );

    assign wb_en      = issue_en;
    assign wb_rob_idx = issue_rob_idx;
    assign wb_rd      = issue_rd;
    assign wb_res     = rdata;   // old value, already masked
    assign wb_exccode = issue_exc_valid ? issue_exccode : `EXC_NONE;

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;   // released away from the active edge
    end

endmodule

`default_nettype wire

// ==== sim/csr_unit_tb.sv ====
`default_nettype none

`include "csr_params.svh"

module csr_unit_tb;

    import backend_pkg::*;
    import csr_pkg::*;

    logic       clk;
    logic       rst;
    logic       issue_en;
    csr_op_t    issue_csrop;
    csr_addr_t  issue_csrid;
    arch_reg_t  issue_imm;
    xlen_t      issue_rs1_data;
    rob_idx_t   issue_rob_idx;
    arch_reg_t  issue_rd;
    logic       issue_exc_valid;
    exc_code_t  issue_exccode;
    logic       wb_en;
    rob_idx_t   wb_rob_idx;
    arch_reg_t  wb_rd;
    xlen_t      wb_res;
    exc_code_t  wb_exccode;
    logic       backend_redirect;
    rob_idx_t   backend_redirect_idx;
    logic       redirect_en;
    exc_code_t  redirect_exccode;
    vaddr_t     exc_pc;
    vaddr_t     target_pc;

    xlen_t       model [CSR_NUM];   // masked contents each csr should read back
    priv_mode_t  model_mode;
    logic [31:0] rand_state;

    tb_clock_gen u_clk (
        .clk(clk),
        .rst(rst)
    );

    csr_unit u_dut (
        .clk                 (clk),
        .rst                 (rst),
        .issue_en            (issue_en),
        .issue_csrop         (issue_csrop),
        .issue_csrid         (issue_csrid),
        .issue_imm           (issue_imm),
        .issue_rs1_data      (issue_rs1_data),
        .issue_rob_idx       (issue_rob_idx),
        .issue_rd            (issue_rd),
        .issue_exc_valid     (issue_exc_valid),
        .issue_exccode       (issue_exccode),
        .wb_en               (wb_en),
        .wb_rob_idx          (wb_rob_idx),
        .wb_rd               (wb_rd),
        .wb_res              (wb_res),
        .wb_exccode          (wb_exccode),
        .backend_redirect    (backend_redirect),
        .backend_redirect_idx(backend_redirect_idx),
        .redirect_en         (redirect_en),
        .redirect_exccode    (redirect_exccode),
        .exc_pc              (exc_pc),
        .target_pc           (target_pc)
    );

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    function automatic xlen_t warl_mask(input int slot);
        case (slot)
            SLOT_MISA: return `ISA_MASK;
            SLOT_MVENDORID, SLOT_MARCHID, SLOT_MIMPID, SLOT_MHARTID: return '0;
            SLOT_MSTATUS, SLOT_SSTATUS: return `STATUS_MASK;
            SLOT_MTVEC, SLOT_STVEC: return `TVEC_MASK;
            SLOT_MIP, SLOT_MIE, SLOT_SIP, SLOT_SIE: return `IP_MASK;
            SLOT_MCAUSE, SLOT_SCAUSE: return `CAUSE_MASK;
            default: return '1;
        endcase
    endfunction

    function automatic int slot_of(input csr_addr_t addr);
        for (int s = 0; s < CSR_NUM; s++) begin
            if (CSR_ADDR_TABLE[s] == addr) begin
                return s;
            end
        end
        return -1;   // unmapped
    endfunction

    // the lower index is older unless the wrap bits differ
    function automatic logic is_older(input rob_idx_t a, input rob_idx_t b);
        if (a[`ROB_WIDTH] == b[`ROB_WIDTH]) begin
            return a[`ROB_WIDTH-1:0] < b[`ROB_WIDTH-1:0];
        end
        return a[`ROB_WIDTH-1:0] > b[`ROB_WIDTH-1:0];
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input xlen_t act, input xlen_t exp);
        assert (act === exp)
        else fail_run($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
    endtask

    task automatic issue_csr(input csr_op_t op, input csr_addr_t addr, input arch_reg_t imm,
                             input xlen_t rs1, input rob_idx_t rob, input logic exc_valid,
                             input logic redir, input rob_idx_t redir_idx);
        int        slot;
        xlen_t     old_val;
        xlen_t     src_val;
        xlen_t     new_val;
        logic      writes;
        arch_reg_t rd;
        exc_code_t code;
        rd   = arch_reg_t'(next_random());
        code = exc_code_t'(next_random());
        @(negedge clk);
        issue_en             = 1'b1;
        issue_csrop          = op;
        issue_csrid          = addr;
        issue_imm            = imm;
        issue_rs1_data       = rs1;
        issue_rob_idx        = rob;
        issue_rd             = rd;
        issue_exc_valid      = exc_valid;
        issue_exccode        = code;
        backend_redirect     = redir;
        backend_redirect_idx = redir_idx;
        redirect_en          = 1'b0;
        slot    = slot_of(addr);
        old_val = (slot >= 0) ? model[slot] : '0;
        src_val = op[2] ? xlen_t'(imm) : rs1;
        case (op[1:0])
            2'b01: new_val = src_val;
            2'b10: new_val = old_val | src_val;
            default: new_val = old_val & ~src_val;
        endcase
        writes = (op[1:0] != 2'b00) && !exc_valid && !(op[1] && imm == '0)
               && !(redir && is_older(redir_idx, rob)) && slot >= 0;
        @(posedge clk);
        check_value("wb_en", xlen_t'(wb_en), xlen_t'(1'b1));
        check_value("wb_res", wb_res, old_val);
        check_value("wb_rd", xlen_t'(wb_rd), xlen_t'(rd));
        check_value("wb_rob_idx", xlen_t'(wb_rob_idx), xlen_t'(rob));
        check_value("wb_exccode", xlen_t'(wb_exccode), xlen_t'(exc_valid ? code : `EXC_NONE));
        if (writes) begin
            model[slot] = new_val & warl_mask(slot);
        end
    endtask

    task automatic write_csr(input csr_op_t op, input csr_addr_t addr, input arch_reg_t imm,
                             input xlen_t rs1);
        issue_csr(op, addr, imm, rs1, rob_idx_t'(next_random()), 1'b0, 1'b0, '0);
    endtask

    task automatic read_csr(input csr_addr_t addr);
        issue_csr(3'b110, addr, 5'd0, '0, rob_idx_t'(next_random()), 1'b0, 1'b0, '0);   // csrrsi 0
    endtask

    task automatic redirect_commit(input exc_code_t code, input vaddr_t pc);
        logic      mret_ok;
        vaddr_t    exp_pc;
        exc_code_t cause;
        xlen_t     st;
        @(negedge clk);
        issue_en         = 1'b0;
        backend_redirect = 1'b0;
        redirect_en      = 1'b1;
        redirect_exccode = code;
        exc_pc           = pc;
        mret_ok = (code == `EXC_MRET) && (model_mode == PRIV_M);
        st      = model[SLOT_MSTATUS];
        exp_pc  = mret_ok ? model[SLOT_MEPC][`VADDR_SIZE-1:0]
                          : {model[SLOT_MTVEC][`VADDR_SIZE-1:2], 2'b00};
        if (code == `EXC_EC) begin
            cause = `EXC_EC + exc_code_t'(model_mode);
        end else if (code == `EXC_MRET) begin
            cause = `EXC_II;
        end else begin
            cause = code;
        end
        @(posedge clk);
        check_value("wb_en", xlen_t'(wb_en), xlen_t'(1'b0));
        check_value("target_pc", xlen_t'(target_pc), xlen_t'(exp_pc));
        if (mret_ok) begin
            model_mode = priv_mode_t'(st[12:11]);
            st[3]      = st[7];
            st[7]      = 1'b1;
        end else begin
            st[12:11]           = model_mode;
            st[7]               = st[3];
            st[3]               = 1'b0;
            model_mode          = PRIV_M;
            model[SLOT_MEPC]    = xlen_t'(pc);
            model[SLOT_MCAUSE]  = xlen_t'(cause);
        end
        model[SLOT_MSTATUS] = st;
    endtask

    initial begin
        int        n;
        int        slot;
        csr_addr_t addr;
        int        rand_slots [4];
        csr_op_t   rand_ops [6];
        rand_slots = '{SLOT_MSCRATCH, SLOT_MTVEC, SLOT_MIE, SLOT_SATP};
        rand_ops   = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};
        rand_state           = 32'hc32c;
        issue_en             = 1'b0;
        issue_csrop          = '0;
        issue_csrid          = '0;
        issue_imm            = '0;
        issue_rs1_data       = '0;
        issue_rob_idx        = '0;
        issue_rd             = '0;
        issue_exc_valid      = 1'b0;
        issue_exccode        = '0;
        backend_redirect     = 1'b0;
        backend_redirect_idx = '0;
        redirect_en          = 1'b0;
        redirect_exccode     = '0;
        exc_pc               = '0;
        for (int s = 0; s < CSR_NUM; s++) begin
            model[s] = '0;
        end
        model[SLOT_MISA] = `MISA_INIT;
        model_mode       = PRIV_M;

        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (rst !== 1'b0 && n < 50);
        if (rst !== 1'b0) begin
            fail_run("reset was never released");
        end
        @(posedge clk);
        check_value("wb_en", xlen_t'(wb_en), xlen_t'(1'b0));
        check_value("target_pc", xlen_t'(target_pc), '0);

        for (int s = 0; s < CSR_NUM; s++) begin
            read_csr(CSR_ADDR_TABLE[s]);
        end
        for (int s = SLOT_MVENDORID; s <= SLOT_MHARTID; s++) begin
            write_csr(3'b001, CSR_ADDR_TABLE[s], 5'd1, {next_random(), next_random()});
            read_csr(CSR_ADDR_TABLE[s]);
        end

        for (int k = 0; k < 40; k++) begin
            slot = rand_slots[next_random() % 4];
            addr = CSR_ADDR_TABLE[slot];
            write_csr(rand_ops[next_random() % 6], addr, arch_reg_t'(next_random()),
                      {next_random(), next_random()});
            read_csr(addr);
        end

        addr = CSR_ADDR_TABLE[SLOT_MSCRATCH];
        write_csr(3'b001, addr, 5'd3, 64'hdead_beef_0123_4567);
        write_csr(3'b010, addr, 5'd0, '1);   // rs1 is x0 so the data is ignored
        write_csr(3'b111, addr, 5'd0, '0);
        read_csr(addr);
        issue_csr(3'b001, addr, 5'd1, 64'h5555_aaaa, 6'd3, 1'b1, 1'b0, '0);
        read_csr(addr);
        write_csr(3'b001, 12'h7c0, 5'd1, {next_random(), next_random()});
        read_csr(12'h7c0);

        issue_csr(3'b001, addr, 5'd1, 64'h11, 6'b0_01010, 1'b0, 1'b1, 6'b0_00100);
        read_csr(addr);
        issue_csr(3'b001, addr, 5'd1, 64'h22, 6'b0_01010, 1'b0, 1'b1, 6'b0_10000);
        read_csr(addr);
        issue_csr(3'b001, addr, 5'd1, 64'h33, 6'b1_00010, 1'b0, 1'b1, 6'b0_11000);
        read_csr(addr);
        issue_csr(3'b001, addr, 5'd1, 64'h44, 6'b0_11000, 1'b0, 1'b1, 6'b1_00010);
        read_csr(addr);

        write_csr(3'b001, CSR_ADDR_TABLE[SLOT_MTVEC], 5'd1, 64'h0000_0000_8000_1237);
        write_csr(3'b110, CSR_ADDR_TABLE[SLOT_MSTATUS], 5'd8, '0);   // set MIE
        redirect_commit(`EXC_BP, vaddr_t'({next_random(), next_random()}));
        read_csr(CSR_ADDR_TABLE[SLOT_MEPC]);
        read_csr(CSR_ADDR_TABLE[SLOT_MCAUSE]);
        read_csr(CSR_ADDR_TABLE[SLOT_MSTATUS]);
        redirect_commit(`EXC_EC, vaddr_t'({next_random(), next_random()}));
        read_csr(CSR_ADDR_TABLE[SLOT_MCAUSE]);
        read_csr(CSR_ADDR_TABLE[SLOT_MSTATUS]);

        write_csr(3'b001, CSR_ADDR_TABLE[SLOT_MEPC], 5'd1, 64'h0000_0040_0000_1000);
        redirect_commit(`EXC_MRET, '0);   // MPIE is clear here
        read_csr(CSR_ADDR_TABLE[SLOT_MSTATUS]);
        write_csr(3'b011, CSR_ADDR_TABLE[SLOT_MSTATUS], 5'd1, 64'h1800);   // MPP to user
        redirect_commit(`EXC_MRET, '0);
        redirect_commit(`EXC_EC, 39'h12_3456_7890);
        read_csr(CSR_ADDR_TABLE[SLOT_MCAUSE]);
        redirect_commit(`EXC_MRET, '0);
        redirect_commit(`EXC_MRET, 39'h00_0000_4444);   // illegal from user mode
        read_csr(CSR_ADDR_TABLE[SLOT_MCAUSE]);
        read_csr(CSR_ADDR_TABLE[SLOT_MEPC]);
        read_csr(CSR_ADDR_TABLE[SLOT_MSTATUS]);

        @(negedge clk);
        issue_en    = 1'b0;
        redirect_en = 1'b0;
        @(posedge clk);
        check_value("wb_en", xlen_t'(wb_en), xlen_t'(1'b0));
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== csr_core.f ====
+incdir+rtl
rtl/backend_pkg.sv
rtl/csr_pkg.sv
rtl/rob_age_compare.sv
rtl/csr_read_select.sv
rtl/csr_trap_ctrl.sv
rtl/csr_unit.sv
sim/tb_clock_gen.sv
sim/csr_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f csr_core.f --top-module csr_unit_tb \
    --Mdir "$BUILD_DIR" -o csr_unit_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/csr_unit_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0
